/* bench/tcb_sys_tb.sv */
/*
 * testbench for the TCB peripheral island
 * clock, reset, request driver, reference model, compare process,
 * check task, timeout and summary
 */
`default_nettype none

module tcb_sys_tb;

  import tcb_pkg::*;

  localparam int          MEM_WORDS = 256;
  localparam int          GPIO_W    = 16;
  // address map as the top level defaults
  localparam tcb_adr_t    MEM_ADR   = 32'h0000_0000;
  localparam tcb_adr_t    MEM_MSK   = 32'hFFFF_FC00;
  localparam tcb_adr_t    GPIO_ADR  = 32'h0000_1000;
  localparam tcb_adr_t    GPIO_MSK  = 32'hFFFF_FFF8;
  localparam logic [31:0] SEED      = 32'h5769_4f83;
  // request counts per test
  localparam int N_MEM    = 12;
  localparam int N_B2B    = 16;
  localparam int N_GOUT   = 6;
  localparam int N_GPI    = 3;
  localparam int N_UNM    = 4;
  localparam int N_REREAD = 5;
  localparam int N_REQ    = 4 * N_MEM + 2 * N_B2B + N_GOUT + 3 * N_GPI + 2 * N_UNM + N_REREAD;
  localparam int LIMIT    = 4 * N_REQ + 100;

  typedef logic [GPIO_W-1:0] pin_t;
  // one accepted transfer
  typedef struct packed {
    logic     wen;
    tcb_ben_t ben;
    tcb_adr_t adr;
    tcb_dat_t wdt;
  } xfer_t;

  logic     sub;
  logic     rst_n;
  tcb_req_t req;
  tcb_rsp_t rsp;
  pin_t     gpo;
  pin_t     gpi;

  // model state and bookkeeping
  tcb_dat_t    mem_model [MEM_WORDS];
  pin_t        gpo_model;
  pin_t        gpi_model;
  xfer_t       xq [$];
  int unsigned used [$];
  int          errors;
  int          checks;
  int          cycles;

  tcb_sys dut (
    .sub   (sub),
    .rst_n (rst_n),
    .req   (req),
    .rsp   (rsp),
    .gpo   (gpo),
    .gpi   (gpi)
  );

  initial begin
    sub = 1'b0;
    forever #2 sub = ~sub;
  end

  //////////////////////////////////////////////////
  // reference model
  //////////////////////////////////////////////////

  // 0 memory, 1 GPIO, 2 unmapped
  function automatic int target(tcb_adr_t a);
    if ((a & MEM_MSK) == MEM_ADR) return 0;
    if ((a & GPIO_MSK) == GPIO_ADR) return 1;
    return 2;
  endfunction

  function automatic tcb_dat_t merge(tcb_dat_t old, tcb_dat_t wdt, tcb_ben_t ben);
    tcb_dat_t w;
    w = old;
    for (int b = 0; b < 4; b++) begin
      if (ben[b]) w[8*b +: 8] = wdt[8*b +: 8];
    end
    return w;
  endfunction

  // expected rdt and err for one transfer, writes read back 0
  function automatic tcb_rsp_t ref_rsp(xfer_t x);
    tcb_rsp_t r;
    r     = '0;
    r.rdy = 1'b1;
    case (target(x.adr))
      // word index is adr[9:2] inside the 1 KB window
      0: if (!x.wen) r.rdt = mem_model[x.adr[9:2]];
      1: begin
        if (x.wen) r.err = x.adr[2];
        else r.rdt = x.adr[2] ? 32'(gpi_model) : 32'(gpo_model);
      end
      default: r.err = 1'b1;
    endcase
    return r;
  endfunction

  task automatic update_model(xfer_t x);
    if (x.wen && target(x.adr) == 0) begin
      mem_model[x.adr[9:2]] = merge(mem_model[x.adr[9:2]], x.wdt, x.ben);
    end
    // lanes above the pin count fall away
    if (x.wen && target(x.adr) == 1 && !x.adr[2]) begin
      gpo_model = pin_t'(merge(32'(gpo_model), x.wdt, x.ben));
    end
  endtask

  task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("ERR %s got %h exp %h at %0t", name, got, exp, $time);
    end
  endtask

  //////////////////////////////////////////////////
  // driver
  //////////////////////////////////////////////////

  function automatic tcb_adr_t mem_adr(int unsigned idx);
    return tcb_adr_t'(idx << 2);
  endfunction

  // called and left at posedge+1, so calls chain back to back
  task automatic issue(input logic wen, input tcb_ben_t ben, input tcb_adr_t adr,
                       input tcb_dat_t wdt);
    xfer_t x;
    int    waits;
    req.vld = 1'b1;
    req.wen = wen;
    req.ben = ben;
    req.adr = adr;
    req.wdt = wdt;
    waits   = 0;
    // rdy sampled mid cycle where it is stable
    @(negedge sub);
    while (!rsp.rdy) begin
      waits++;
      @(negedge sub);
    end
    x.wen = wen;
    x.ben = ben;
    x.adr = adr;
    x.wdt = wdt;
    xq.push_back(x);
    // GPIO holds rdy low for exactly one cycle
    check("rsp.rdy waits", 32'(waits), (target(adr) == 1) ? 32'd1 : 32'd0);
    @(posedge sub);
    #1;
    req.vld = 1'b0;
  endtask

  task automatic idle(input int n);
    repeat (n) begin
      @(posedge sub);
      #1;
    end
  endtask

  //////////////////////////////////////////////////
  // compare and timeout
  //////////////////////////////////////////////////

  initial begin : compare
    xfer_t    x;
    tcb_rsp_t exp;
    logic     rsp_due;
    rsp_due = 1'b0;
    forever begin
      @(negedge sub);
      // response of the transfer at the last rising edge
      if (rsp_due) begin
        if (xq.size() == 0) begin
          errors++;
          $display("response cycle with no transfer recorded at %0t", $time);
        end else begin
          x   = xq.pop_front();
          exp = ref_rsp(x);
          check("rsp.rdt", rsp.rdt, exp.rdt);
          check("rsp.err", 32'(rsp.err), 32'(exp.err));
          update_model(x);
          check("gpo", 32'(gpo), 32'(gpo_model));
        end
      end
      rsp_due = rst_n && req.vld && rsp.rdy;
    end
  end

  initial begin : timeout
    cycles = 0;
    while (cycles < LIMIT) begin
      @(posedge sub);
      cycles++;
    end
    errors++;
    $display("timeout: the tests did not finish within %0d cycles", LIMIT);
    $display("checks: %0d  errors: %0d", checks, errors);
    $display("Errors found");
    $finish;
  end

  //////////////////////////////////////////////////
  // tests
  //////////////////////////////////////////////////

  initial begin : main
    int unsigned idx;
    tcb_adr_t    unm [N_UNM];
    void'($urandom(SEED));
    errors    = 0;
    checks    = 0;
    rst_n     = 1'b0;
    req       = '0;
    gpi       = '0;
    gpo_model = '0;
    gpi_model = '0;
    unm       = '{32'h0000_0400, 32'h0000_1008, 32'h0000_0FFC, 32'h8000_1000};
    repeat (3) @(posedge sub);
    #1;
    rst_n = 1'b1;
    // state right after reset
    @(negedge sub);
    check("rsp.rdy", 32'(rsp.rdy), 32'd1);
    check("gpo", 32'(gpo), 32'd0);
    @(posedge sub);
    #1;

    // memory full words, then byte lanes
    for (int i = 0; i < N_MEM; i++) begin
      // first and last word, where unmapped addresses would alias
      if (i == 0) begin
        idx = 0;
      end else if (i == 1) begin
        idx = MEM_WORDS - 1;
      end else begin
        idx = $urandom_range(MEM_WORDS - 1);
      end
      used.push_back(idx);
      issue(1'b1, 4'hF, mem_adr(idx), $urandom);
    end
    foreach (used[i]) issue(1'b0, 4'hF, mem_adr(used[i]), '0);
    foreach (used[i]) issue(1'b1, tcb_ben_t'($urandom_range(15)), mem_adr(used[i]), $urandom);
    foreach (used[i]) issue(1'b0, 4'hF, mem_adr(used[i]), '0);

    // write then read of the same word on the next cycle
    for (int i = 0; i < N_B2B; i++) begin
      idx = used[$urandom_range(used.size() - 1)];
      issue(1'b1, tcb_ben_t'($urandom_range(15)), mem_adr(idx), $urandom);
      issue(1'b0, 4'hF, mem_adr(idx), '0);
    end

    // GPIO output, upper data bits set so the read shows them cleared
    issue(1'b1, 4'hF, GPIO_ADR, $urandom | 32'hA5A5_0000);
    issue(1'b0, 4'hF, GPIO_ADR, '0);
    issue(1'b1, 4'b0010, GPIO_ADR, $urandom);
    issue(1'b0, 4'hF, GPIO_ADR, '0);
    issue(1'b1, 4'b0100, GPIO_ADR, $urandom);
    issue(1'b0, 4'hF, GPIO_ADR, '0);

    // GPIO input through the synchronizer
    for (int i = 0; i < N_GPI; i++) begin
      gpi       = pin_t'($urandom);
      gpi_model = gpi;
      idle(4);
      issue(1'b0, 4'hF, GPIO_ADR + 4, '0);
      issue(1'b1, 4'hF, GPIO_ADR + 4, $urandom);
      issue(1'b0, 4'hF, GPIO_ADR, '0);
    end

    // unmapped, then reread what must be untouched
    foreach (unm[i]) begin
      issue(1'b1, 4'hF, unm[i], $urandom);
      issue(1'b0, 4'hF, unm[i], '0);
    end
    // used[0] and used[1] are the aliased first and last word
    for (int i = 0; i < N_REREAD - 1; i++) issue(1'b0, 4'hF, mem_adr(used[i]), '0);
    issue(1'b0, 4'hF, GPIO_ADR, '0);

    idle(2);
    if (xq.size() != 0) begin
      errors++;
      $display("%0d transfers never got a response", xq.size());
    end
    $display("checks: %0d  errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* flist.f */
source/tcb_pkg.sv
source/tcb_dec.sv
source/tcb_mem.sv
source/tcb_gpio.sv
source/tcb_sys.sv
bench/tcb_sys_tb.sv

/* run.sh */
#!/usr/bin/env bash
# build and run the TCB island testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary -j 0 --top-module tcb_sys_tb -f flist.f -o tcb_sim

# the testbench ends with $finish in both cases, so the log decides
./obj_dir/tcb_sim > sim.log
cat sim.log

if grep -q "Errors found" sim.log; then
  echo "simulation failed"
  exit 1
fi
echo "simulation passed"

/* source/tcb_dec.sv */
/*
 * TCB address decoder
 * request fan-out to memory and GPIO, response multiplexer,
 * error responder for unmapped addresses
 */
`default_nettype none

module tcb_dec #(
  // base and mask per port, index 0 memory, index 1 GPIO
  parameter tcb_pkg::tcb_map_t DEC_ADR = {32'h0000_1000, 32'h0000_0000},
  parameter tcb_pkg::tcb_map_t DEC_MSK = {32'hFFFF_FFF8, 32'hFFFF_FC00}
)(
  input  logic              sub,
  input  logic              rst_n,
  // subordinate side, outside manager connects here
  input  tcb_pkg::tcb_req_t req,
  output tcb_pkg::tcb_rsp_t rsp,
  // manager side, one per peripheral
  output tcb_pkg::tcb_req_t mem_req,
  input  tcb_pkg::tcb_rsp_t mem_rsp,
  output tcb_pkg::tcb_req_t gpio_req,
  input  tcb_pkg::tcb_rsp_t gpio_rsp
);

  import tcb_pkg::*;

  // select codes 0..TCB_PN-1 plus one extra "none" code
  localparam int unsigned SW = $clog2(TCB_PN + 1);
  typedef logic [SW-1:0] sel_t;
  localparam sel_t SEL_NONE = sel_t'(TCB_PN);

  logic [TCB_PN-1:0] dec_hit;
  // request phase select, combinational
  sel_t              req_sel;
  // response phase select, registered on transfer
  sel_t              rsp_sel;
  logic              trn;

  // ports mapped into arrays for indexing
  tcb_req_t [TCB_PN-1:0] prt_req;
  tcb_rsp_t [TCB_PN-1:0] prt_rsp;

  assign mem_req  = prt_req[TCB_PORT_MEM];
  assign gpio_req = prt_req[TCB_PORT_GPIO];

  assign prt_rsp[TCB_PORT_MEM]  = mem_rsp;
  assign prt_rsp[TCB_PORT_GPIO] = gpio_rsp;

  //////////////////////////////////////////////////
  // decoder
  //////////////////////////////////////////////////

  // masked address against masked base, one bit per port
  always_comb begin
    for (int i = 0; i < TCB_PN; i++) begin
      dec_hit[i] = (req.adr & DEC_MSK[i]) == (DEC_ADR[i] & DEC_MSK[i]);
    end
  end

  // priority pick, walked downwards so the lowest hit is kept
  always_comb begin
    req_sel = SEL_NONE;
    for (int i = TCB_PN - 1; i >= 0; i--) begin
      if (dec_hit[i]) begin
        req_sel = sel_t'(i);
      end
    end
  end

  // shared fields go everywhere, vld only to the selected port
  always_comb begin
    for (int i = 0; i < TCB_PN; i++) begin
      prt_req[i]     = req;
      prt_req[i].vld = req.vld & (req_sel == sel_t'(i));
    end
  end

  //////////////////////////////////////////////////
  // response
  //////////////////////////////////////////////////

  assign trn = req.vld & rsp.rdy;

  // remember who answers in the next cycle
  always_ff @(posedge sub or negedge rst_n) begin
    if (!rst_n) begin
      rsp_sel <= sel_t'(TCB_PORT_MEM);
    end else if (trn) begin
      rsp_sel <= req_sel;
    end
  end

  // unmapped default: ready at once, then rdt 0 with err
  always_comb begin
    rsp.rdy = 1'b1;
    rsp.rdt = '0;
    rsp.err = 1'b1;
    for (int i = 0; i < TCB_PN; i++) begin
      // request phase follows the live decode
      if (req_sel == sel_t'(i)) begin
        rsp.rdy = prt_rsp[i].rdy;
      end
      // response phase follows the registered select
      if (rsp_sel == sel_t'(i)) begin
        rsp.rdt = prt_rsp[i].rdt;
        rsp.err = prt_rsp[i].err;
      end
    end
  end

endmodule

`default_nettype wire

/* source/tcb_gpio.sv */
/*
 * TCB GPIO
 * output register at offset 0, synchronized input at offset 4,
 * one wait state per request, err on write to the input
 */
`default_nettype none

module tcb_gpio #(
  // pin count, 1 to 32
  parameter int unsigned GPIO_W = 16
)(
  input  logic              sub,
  input  logic              rst_n,
  input  tcb_pkg::tcb_req_t req,
  output tcb_pkg::tcb_rsp_t rsp,
  output logic [GPIO_W-1:0] gpo,
  input  logic [GPIO_W-1:0] gpi
);

  import tcb_pkg::*;

  // address bit that picks the register
  localparam int unsigned REG_SEL = 2;
  typedef logic [GPIO_W-1:0] gpio_t;

  gpio_t    gpo_q;
  gpio_t    gpi_meta;
  gpio_t    gpi_sync;
  tcb_dat_t gpo_wrd;
  tcb_dat_t rdt_q;
  logic     err_q;
  logic     wait_q;
  logic     reg_gpi;
  logic     trn;

  //////////////////////////////////////////////////
  // handshake
  //////////////////////////////////////////////////

  // set on first request cycle, cleared by the transfer
  always_ff @(posedge sub or negedge rst_n) begin
    if (!rst_n) begin
      wait_q <= 1'b0;
    end else begin
      wait_q <= req.vld & ~wait_q;
    end
  end

  assign trn     = req.vld & wait_q;
  assign reg_gpi = req.adr[REG_SEL];

  //////////////////////////////////////////////////
  // registers
  //////////////////////////////////////////////////

  // merge enabled lanes over current output value
  always_comb begin
    gpo_wrd = tcb_dat_t'(gpo_q);
    for (int b = 0; b < TCB_BW; b++) begin
      if (req.ben[b]) begin
        gpo_wrd[8*b +: 8] = req.wdt[8*b +: 8];
      end
    end
  end

  always_ff @(posedge sub or negedge rst_n) begin
    if (!rst_n) begin
      gpo_q    <= '0;
      gpi_meta <= '0;
      gpi_sync <= '0;
    end else begin
      // two flop sync, gpi is async to sub
      gpi_meta <= gpi;
      gpi_sync <= gpi_meta;
      if (trn && req.wen && !reg_gpi) begin
        gpo_q <= gpo_wrd[GPIO_W-1:0];
      end
    end
  end

  // input register is read only
  always_ff @(posedge sub or negedge rst_n) begin
    if (!rst_n) begin
      err_q <= 1'b0;
    end else if (trn) begin
      err_q <= req.wen & reg_gpi;
    end
  end

  // upper bits read as zero
  always_ff @(posedge sub) begin
    if (trn) begin
      if (req.wen) begin
        rdt_q <= '0;
      end else begin
        rdt_q <= reg_gpi ? tcb_dat_t'(gpi_sync) : tcb_dat_t'(gpo_q);
      end
    end
  end

  assign gpo     = gpo_q;
  assign rsp.rdt = rdt_q;
  assign rsp.err = err_q;
  assign rsp.rdy = wait_q;

endmodule

`default_nettype wire

/* source/tcb_mem.sv */
/*
 * TCB word memory
 * byte-enable writes, registered read, no wait states
 */
`default_nettype none

module tcb_mem #(
  // depth in words, power of two
  parameter int unsigned MEM_WORDS = 256
)(
  input  logic              sub,
  input  logic              rst_n,
  input  tcb_pkg::tcb_req_t req,
  output tcb_pkg::tcb_rsp_t rsp
);

  import tcb_pkg::*;

  // byte offset bits and word index bits
  localparam int unsigned OFF = $clog2(TCB_BW);
  localparam int unsigned MAW = $clog2(MEM_WORDS);
  typedef logic [MAW-1:0] mem_adr_t;

  tcb_dat_t mem [MEM_WORDS];
  mem_adr_t wrd;
  tcb_dat_t rdt_q;
  logic     trn;

  // address wraps modulo depth
  assign wrd = req.adr[OFF +: MAW];

  // rdy is tied high, so every vld is a transfer
  assign trn = req.vld;

  //////////////////////////////////////////////////
  // storage
  //////////////////////////////////////////////////

  // only enabled lanes are written
  always_ff @(posedge sub) begin
    if (trn && req.wen) begin
      for (int b = 0; b < TCB_BW; b++) begin
        if (req.ben[b]) begin
          mem[wrd][8*b +: 8] <= req.wdt[8*b +: 8];
        end
      end
    end
  end

  // read data one cycle after transfer, zero for writes
  always_ff @(posedge sub or negedge rst_n) begin
    if (!rst_n) begin
      rdt_q <= '0;
    end else if (trn) begin
      rdt_q <= req.wen ? '0 : mem[wrd];
    end
  end

  assign rsp.rdt = rdt_q;
  assign rsp.err = 1'b0;
  assign rsp.rdy = 1'b1;

endmodule

`default_nettype wire

/* source/tcb_pkg.sv */
/*
 * shared TCB definitions
 * bus widths, vector typedefs, request and response structs,
 * decoder port count, port indices and address map type
 */
`default_nettype none

package tcb_pkg;

  //////////////////////////////////////////////////
  // widths
  //////////////////////////////////////////////////

  // byte address and data word
  localparam int unsigned TCB_AW = 32;
  localparam int unsigned TCB_DW = 32;
  // one enable per byte lane
  localparam int unsigned TCB_BW = TCB_DW / 8;

  typedef logic [TCB_AW-1:0] tcb_adr_t;
  typedef logic [TCB_DW-1:0] tcb_dat_t;
  typedef logic [TCB_BW-1:0] tcb_ben_t;

  //////////////////////////////////////////////////
  // bus structs
  //////////////////////////////////////////////////

  // request phase, manager to subordinate
  typedef struct packed {
    logic     vld;
    logic     wen;
    tcb_ben_t ben;
    tcb_adr_t adr;
    tcb_dat_t wdt;
  } tcb_req_t;

  // rdt/err belong to the response phase, rdy to the request phase
  typedef struct packed {
    tcb_dat_t rdt;
    logic     err;
    logic     rdy;
  } tcb_rsp_t;

  // decoded ports and their order, lowest index wins on overlap
  localparam int unsigned TCB_PN        = 2;
  localparam int unsigned TCB_PORT_MEM  = 0;
  localparam int unsigned TCB_PORT_GPIO = 1;

  // one base or mask per decoded port
  typedef tcb_adr_t [TCB_PN-1:0] tcb_map_t;

endpackage

`default_nettype wire

/* source/tcb_sys.sv */
/*
 * TCB peripheral island top
 * decoder with word memory and GPIO behind it
 */
`default_nettype none

module tcb_sys #(
  // memory depth in words
  parameter int unsigned       MEM_WORDS = 256,
  // GPIO pin count
  parameter int unsigned       GPIO_W    = 16,
  // decoder map, index 0 memory, index 1 GPIO
  parameter tcb_pkg::tcb_map_t DEC_ADR   = {32'h0000_1000, 32'h0000_0000},
  parameter tcb_pkg::tcb_map_t DEC_MSK   = {32'hFFFF_FFF8, 32'hFFFF_FC00}
)(
  input  logic              sub,
  input  logic              rst_n,
  // external manager port
  input  tcb_pkg::tcb_req_t req,
  output tcb_pkg::tcb_rsp_t rsp,
  // GPIO pins
  output logic [GPIO_W-1:0] gpo,
  input  logic [GPIO_W-1:0] gpi
);

  import tcb_pkg::*;

  // decoder to peripheral links
  tcb_req_t mem_req;
  tcb_rsp_t mem_rsp;
  tcb_req_t gpio_req;
  tcb_rsp_t gpio_rsp;

  //////////////////////////////////////////////////
  // decoder
  //////////////////////////////////////////////////

  tcb_dec #(
    .DEC_ADR (DEC_ADR),
    .DEC_MSK (DEC_MSK)
  ) u_dec (
    .sub      (sub),
    .rst_n    (rst_n),
    .req      (req),
    .rsp      (rsp),
    .mem_req  (mem_req),
    .mem_rsp  (mem_rsp),
    .gpio_req (gpio_req),
    .gpio_rsp (gpio_rsp)
  );

  //////////////////////////////////////////////////
  // peripherals
  //////////////////////////////////////////////////

  // zero wait state memory
  tcb_mem #(
    .MEM_WORDS (MEM_WORDS)
  ) u_mem (
    .sub   (sub),
    .rst_n (rst_n),
    .req   (mem_req),
    .rsp   (mem_rsp)
  );

  // one wait state GPIO
  tcb_gpio #(
    .GPIO_W (GPIO_W)
  ) u_gpio (
    .sub   (sub),
    .rst_n (rst_n),
    .req   (gpio_req),
    .rsp   (gpio_rsp),
    .gpo   (gpo),
    .gpi   (gpi)
  );

endmodule

`default_nettype wire
